// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache_miss_cam
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TB PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/dcache_miss_cam.sv
`timescale 1ns/1ps

module dcache_miss_cam #(
  parameter int N_PORTS   = 4,
  parameter int N_ENTRIES = 16
) (
  input  logic                                     clk,
  input  logic                                     rst,
  input  dcache_miss_pkg::miss_req_t [N_PORTS-1:0] miss_i,
  input  logic                                     rd_en_i,
  input  logic [$clog2(N_ENTRIES)-1:0]             rd_idx_i,
  input  logic                                     unlock_i,
  output dcache_miss_pkg::refill_t                 refill_o,
  output logic                                     has_free_o,
  output logic                                     locked_o
);

  localparam int IDX_W = $clog2(N_ENTRIES);

  dcache_miss_pkg::miss_req_t [N_PORTS-1:0]               acc;
  dcache_miss_pkg::refill_t                               sel;
  logic [N_ENTRIES-1:0]                                   busy;
  logic [N_ENTRIES-1:0][dcache_miss_pkg::LINE_ADDR_W-1:0] busy_addr;
  logic                                                   locked;
  logic                                                   clear_en;
  logic [IDX_W-1:0]                                       clear_idx;

  miss_filter #(
    .N_PORTS  (N_PORTS),
    .N_ENTRIES(N_ENTRIES)
  ) miss_filter_inst (
    .clk        (clk),
    .rst        (rst),
    .miss_i     (miss_i),
    .locked_i   (locked),
    .busy_i     (busy),
    .busy_addr_i(busy_addr),
    .acc_o      (acc)
  );

  miss_entry_file #(
    .N_PORTS  (N_PORTS),
    .N_ENTRIES(N_ENTRIES)
  ) miss_entry_file_inst (
    .clk        (clk),
    .rst        (rst),
    .acc_i      (acc),
    .clear_en_i (clear_en),
    .clear_idx_i(clear_idx),
    .unlock_i   (unlock_i),
    .rd_idx_i   (rd_idx_i),
    .sel_o      (sel),
    .busy_o     (busy),
    .busy_addr_o(busy_addr),
    .has_free_o (has_free_o),
    .locked_o   (locked)
  );

  refill_reader #(
    .N_ENTRIES(N_ENTRIES)
  ) refill_reader_inst (
    .clk        (clk),
    .rst        (rst),
    .rd_en_i    (rd_en_i),
    .rd_idx_i   (rd_idx_i),
    .sel_i      (sel),
    .refill_o   (refill_o),
    .clear_en_o (clear_en),
    .clear_idx_o(clear_idx)
  );

  assign locked_o = locked;

endmodule

// File: source/dcache_miss_pkg.sv
package dcache_miss_pkg;

  // ==============================
  // Address geometry
  // ==============================

  localparam int PADDR_W     = 44;
  localparam int LINE_OFFS_W = 8;
  localparam int LINE_ADDR_W = PADDR_W - LINE_OFFS_W; // 36 bit line address

  // ==============================
  // Request and result records
  // ==============================

  // One load or store miss presented on a port
  typedef struct packed {
    logic                   valid;
    logic                   st;        // Set for a store miss
    logic [LINE_ADDR_W-1:0] line_addr;
  } miss_req_t;

  // Entry contents returned by a refill read
  typedef struct packed {
    logic                   valid;     // Entry was filled and not yet read
    logic                   st;
    logic [LINE_ADDR_W-1:0] line_addr;
  } refill_t;

  // ==============================
  // Entry life cycle
  // ==============================

  // FREE -> FILLED on allocation, FILLED -> DRAINED on refill read,
  // any busy state -> FREE on unlock
  typedef enum logic [1:0] {
    ENTRY_FREE    = 2'b00,
    ENTRY_FILLED  = 2'b01,
    ENTRY_DRAINED = 2'b10
  } entry_state_e;

endpackage

// File: source/miss_entry_file.sv
`timescale 1ns/1ps

module miss_entry_file #(
  parameter int N_PORTS   = 4,
  parameter int N_ENTRIES = 16
) (
  input  logic                                                   clk,
  input  logic                                                   rst,
  input  dcache_miss_pkg::miss_req_t [N_PORTS-1:0]               acc_i,
  input  logic                                                   clear_en_i,
  input  logic [$clog2(N_ENTRIES)-1:0]                           clear_idx_i,
  input  logic                                                   unlock_i,
  input  logic [$clog2(N_ENTRIES)-1:0]                           rd_idx_i,
  output dcache_miss_pkg::refill_t                               sel_o,
  output logic [N_ENTRIES-1:0]                                   busy_o,
  output logic [N_ENTRIES-1:0][dcache_miss_pkg::LINE_ADDR_W-1:0] busy_addr_o,
  output logic                                                   has_free_o,
  output logic                                                   locked_o
);

  localparam int PORT_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

  dcache_miss_pkg::entry_state_e state_q [N_ENTRIES];

  logic [N_ENTRIES-1:0][dcache_miss_pkg::LINE_ADDR_W-1:0] addr_q;
  logic [N_ENTRIES-1:0]                                   st_q;
  logic [N_ENTRIES-1:0]                                   free_mask;
  logic [N_ENTRIES-1:0]                                   avail;
  logic [N_ENTRIES-1:0]                                   grant;
  logic [N_ENTRIES-1:0][PORT_W-1:0]                       grant_port;
  logic                                                   found;
  logic                                                   any_req;
  logic                                                   locked_q;

  always_comb begin
    for (int e = 0; e < N_ENTRIES; e++) begin
      free_mask[e] = (state_q[e] == dcache_miss_pkg::ENTRY_FREE);
      busy_o[e]    = !free_mask[e]; // FILLED and DRAINED both hold the line
    end
  end

  // ==============================
  // Lowest-free-entry allocation
  // ==============================

  // Ports are served in ascending order, each taking the lowest entry still free
  always_comb begin
    avail      = free_mask;
    grant      = '0;
    grant_port = '0;
    found      = 1'b0;
    any_req    = 1'b0;
    for (int p = 0; p < N_PORTS; p++) begin
      found = 1'b0;
      for (int e = 0; e < N_ENTRIES; e++) begin
        if (acc_i[p].valid && !found && avail[e]) begin
          found         = 1'b1;
          avail[e]      = 1'b0;
          grant[e]      = 1'b1;
          grant_port[e] = PORT_W'(p);
        end
      end
      if (acc_i[p].valid) begin
        any_req = 1'b1;
      end
    end
  end

  // ==============================
  // Entry state and payload
  // ==============================

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int e = 0; e < N_ENTRIES; e++) begin
        state_q[e] <= dcache_miss_pkg::ENTRY_FREE;
      end
    end else if (unlock_i) begin
      for (int e = 0; e < N_ENTRIES; e++) begin
        state_q[e] <= dcache_miss_pkg::ENTRY_FREE;
      end
    end else begin
      for (int e = 0; e < N_ENTRIES; e++) begin
        if (grant[e]) begin
          state_q[e] <= dcache_miss_pkg::ENTRY_FILLED;
        end
      end
      // Clear only targets FILLED entries, allocation only FREE ones
      if (clear_en_i && state_q[clear_idx_i] == dcache_miss_pkg::ENTRY_FILLED) begin
        state_q[clear_idx_i] <= dcache_miss_pkg::ENTRY_DRAINED;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int e = 0; e < N_ENTRIES; e++) begin
      if (grant[e]) begin
        addr_q[e] <= acc_i[grant_port[e]].line_addr;
        st_q[e]   <= acc_i[grant_port[e]].st;
      end
    end
  end

  // A request that finds no entry, or takes the last one, leaves nothing free
  always_ff @(posedge clk) begin
    if (rst) begin
      locked_q <= 1'b0;
    end else if (unlock_i) begin
      locked_q <= 1'b0;
    end else if (any_req && !(|avail)) begin
      locked_q <= 1'b1;
    end
  end

  assign busy_addr_o     = addr_q;
  assign has_free_o      = |free_mask;
  assign locked_o        = locked_q;
  assign sel_o.valid     = (state_q[rd_idx_i] == dcache_miss_pkg::ENTRY_FILLED);
  assign sel_o.st        = st_q[rd_idx_i];
  assign sel_o.line_addr = addr_q[rd_idx_i];

endmodule

// File: source/miss_filter.sv
`timescale 1ns/1ps

module miss_filter #(
  parameter int N_PORTS   = 4,
  parameter int N_ENTRIES = 16
) (
  input  logic                                                  clk,
  input  logic                                                  rst,
  input  dcache_miss_pkg::miss_req_t [N_PORTS-1:0]              miss_i,
  input  logic                                                  locked_i,
  input  logic [N_ENTRIES-1:0]                                  busy_i,
  input  logic [N_ENTRIES-1:0][dcache_miss_pkg::LINE_ADDR_W-1:0] busy_addr_i,
  output dcache_miss_pkg::miss_req_t [N_PORTS-1:0]              acc_o
);

  logic [N_PORTS-1:0]                                   keep;
  logic [N_PORTS-1:0]                                   acc_vld_q;
  logic [N_PORTS-1:0]                                   acc_st_q;
  logic [N_PORTS-1:0][dcache_miss_pkg::LINE_ADDR_W-1:0] acc_addr_q;

  // ==============================
  // Duplicate suppression
  // ==============================

  always_comb begin
    for (int p = 0; p < N_PORTS; p++) begin
      keep[p] = miss_i[p].valid && !locked_i; // Nothing enters while the buffer is locked

      // A higher port with the same line wins, so only one copy survives
      for (int q = p + 1; q < N_PORTS; q++) begin
        if (miss_i[q].valid && miss_i[q].line_addr == miss_i[p].line_addr) begin
          keep[p] = 1'b0;
        end
      end

      // CAM lookup against entries that already track this line
      for (int e = 0; e < N_ENTRIES; e++) begin
        if (busy_i[e] && busy_addr_i[e] == miss_i[p].line_addr) begin
          keep[p] = 1'b0;
        end
      end

      // Requests accepted last cycle are not yet visible as busy entries
      for (int q = 0; q < N_PORTS; q++) begin
        if (acc_vld_q[q] && acc_addr_q[q] == miss_i[p].line_addr) begin
          keep[p] = 1'b0;
        end
      end
    end
  end

  // ==============================
  // Request pipeline register
  // ==============================

  always_ff @(posedge clk) begin
    if (rst) begin
      acc_vld_q <= '0;
    end else begin
      acc_vld_q <= keep;
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < N_PORTS; p++) begin
      acc_st_q[p]   <= miss_i[p].st;
      acc_addr_q[p] <= miss_i[p].line_addr;
    end
  end

  always_comb begin
    for (int p = 0; p < N_PORTS; p++) begin
      acc_o[p].valid     = acc_vld_q[p];
      acc_o[p].st        = acc_st_q[p];
      acc_o[p].line_addr = acc_addr_q[p];
    end
  end

endmodule

// File: source/refill_reader.sv
`timescale 1ns/1ps

module refill_reader #(
  parameter int N_ENTRIES = 16
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  rd_en_i,
  input  logic [$clog2(N_ENTRIES)-1:0]          rd_idx_i,
  input  dcache_miss_pkg::refill_t              sel_i,
  output dcache_miss_pkg::refill_t              refill_o,
  output logic                                  clear_en_o,
  output logic [$clog2(N_ENTRIES)-1:0]          clear_idx_o
);

  logic                                   vld_q;
  logic                                   st_q;
  logic [dcache_miss_pkg::LINE_ADDR_W-1:0] addr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= rd_en_i && sel_i.valid; // One cycle pulse per read
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      st_q   <= sel_i.st;
      addr_q <= sel_i.line_addr;
    end
  end

  // The entry leaves FILLED on the same edge that captures it
  assign clear_en_o  = rd_en_i;
  assign clear_idx_o = rd_idx_i;

  assign refill_o.valid     = vld_q;
  assign refill_o.st        = st_q;
  assign refill_o.line_addr = addr_q;

endmodule

// File: sources.f
source/dcache_miss_pkg.sv
source/miss_filter.sv
source/miss_entry_file.sv
source/refill_reader.sv
source/dcache_miss_cam.sv
verification/miss_cam_properties.sv
verification/tb_dcache_miss_cam.sv

// File: verification/miss_cam_properties.sv
`timescale 1ns/1ps

module miss_cam_properties #(
  parameter int N_ENTRIES = 16
) (
  input logic                         clk,
  input logic                         rst,
  input logic                         rd_en_i,
  input logic [$clog2(N_ENTRIES)-1:0] rd_idx_i,
  input logic                         unlock_i,
  input logic                         refill_valid_i,
  input logic                         has_free_i,
  input logic                         locked_i
);

  int fail_count = 0;

  // A second read of the same entry right after a valid one finds it drained
  read_drains_entry: assert property (@(posedge clk) disable iff (rst)
    (refill_valid_i && rd_en_i && rd_idx_i == $past(rd_idx_i)) |=> !refill_valid_i)
    else begin
      fail_count++;
      $error("refill valid on two cycles for one filled entry");
    end

  // Entries only free up on unlock, which also drops the lock
  locked_means_full: assert property (@(posedge clk) disable iff (rst)
    locked_i |-> !has_free_i)
    else begin
      fail_count++;
      $error("buffer locked while a free entry exists");
    end

  unlock_drops_lock: assert property (@(posedge clk) disable iff (rst)
    unlock_i |=> !locked_i)
    else begin
      fail_count++;
      $error("locked still set one cycle after unlock");
    end

endmodule

bind dcache_miss_cam miss_cam_properties #(
  .N_ENTRIES(N_ENTRIES)
) miss_cam_properties_inst (
  .clk           (clk),
  .rst           (rst),
  .rd_en_i       (rd_en_i),
  .rd_idx_i      (rd_idx_i),
  .unlock_i      (unlock_i),
  .refill_valid_i(refill_o.valid),
  .has_free_i    (has_free_o),
  .locked_i      (locked_o)
);

// File: verification/miss_vectors.txt
# cmd vmask smask addr0 addr1 addr2 addr3 rd_idx exp_valid exp_st exp_addr exp_free exp_locked
# Expected columns are the DUT outputs one clock after the line is driven
MISS   1 1 000001000 000000000 000000000 000000000 0  0 0 000000000 1 0
IDLE   0 0 000000000 000000000 000000000 000000000 0  0 0 000000000 1 0
READ   0 0 000000000 000000000 000000000 000000000 0  1 1 000001000 1 0
UNLOCK 0 0 000000000 000000000 000000000 000000000 0  0 0 000000000 1 0
MISS   3 2 000002000 000002000 000000000 000000000 0  0 0 000000000 1 0
IDLE   0 0 000000000 000000000 000000000 000000000 0  0 0 000000000 1 0
READ   0 0 000000000 000000000 000000000 000000000 0  1 1 000002000 1 0
READ   0 0 000000000 000000000 000000000 000000000 1  0 0 000000000 1 0
MISS   4 0 000000000 000000000 000002000 000000000 0  0 0 000000000 1 0
MISS   1 0 000003000 000000000 000000000 000000000 0  0 0 000000000 1 0
MISS   8 0 000000000 000000000 000000000 000003000 0  0 0 000000000 1 0
MISS   2 0 000000000 000003000 000000000 000000000 0  0 0 000000000 1 0
IDLE   0 0 000000000 000000000 000000000 000000000 0  0 0 000000000 1 0
READ   0 0 000000000 000000000 000000000 000000000 1  1 0 000003000 1 0
READ   0 0 000000000 000000000 000000000 000000000 1  0 0 000000000 1 0
MISS   f 5 000004000 000005000 000006000 000007000 0  0 0 000000000 1 0
IDLE   0 0 000000000 000000000 000000000 000000000 0  0 0 000000000 1 0
READ   0 0 000000000 000000000 000000000 000000000 2  1 1 000004000 1 0
READ   0 0 000000000 000000000 000000000 000000000 5  1 0 000007000 1 0
MISS   f 0 000008000 000009000 00000a000 00000b000 0  0 0 000000000 1 0
MISS   f 0 00000c000 00000d000 00000e000 00000f000 0  0 0 000000000 1 0
MISS   3 0 000010000 000011000 000000000 000000000 0  0 0 000000000 1 0
MISS   1 0 000020000 000000000 000000000 000000000 0  0 0 000000000 0 1
MISS   1 0 000021000 000000000 000000000 000000000 0  0 0 000000000 0 1
IDLE   0 0 000000000 000000000 000000000 000000000 0  0 0 000000000 0 1
READ   0 0 000000000 000000000 000000000 000000000 f  1 0 000011000 0 1
UNLOCK 0 0 000000000 000000000 000000000 000000000 0  0 0 000000000 1 0
MISS   1 1 000030000 000000000 000000000 000000000 0  0 0 000000000 1 0
IDLE   0 0 000000000 000000000 000000000 000000000 0  0 0 000000000 1 0
READ   0 0 000000000 000000000 000000000 000000000 0  1 1 000030000 1 0
READ   0 0 000000000 000000000 000000000 000000000 1  0 0 000000000 1 0

// File: verification/tb_dcache_miss_cam.sv
`timescale 1ns/1ps

module tb_dcache_miss_cam;

  localparam int N_PORTS    = 4;
  localparam int N_ENTRIES  = 16;
  localparam int IDX_W      = $clog2(N_ENTRIES);
  localparam int ADDR_W     = dcache_miss_pkg::LINE_ADDR_W;
  localparam int MAX_CYCLES = 400;

  localparam logic [63:0] CMD_MISS    = 64'("MISS");
  localparam logic [63:0] CMD_READ    = 64'("READ");
  localparam logic [63:0] CMD_UNLOCK  = 64'("UNLOCK");
  localparam logic [63:0] CMD_IDLE    = 64'("IDLE");
  localparam logic [63:0] CMD_COMMENT = 64'("#");

  typedef struct packed {
    logic              valid;
    logic              st;
    logic [ADDR_W-1:0] line_addr;
    logic              has_free;
    logic              locked;
  } expect_t;

  logic                                     clk;
  logic                                     rst;
  dcache_miss_pkg::miss_req_t [N_PORTS-1:0] miss;
  logic                                     rd_en;
  logic [IDX_W-1:0]                         rd_idx;
  logic                                     unlock;
  dcache_miss_pkg::refill_t                 refill;
  logic                                     has_free;
  logic                                     locked;

  int                 fd;
  int                 code;
  int                 cycles;
  int                 line_no;
  int                 prev_line;
  logic               done;
  logic               have_prev;
  logic [63:0]        cmd;
  logic [8*128-1:0]   comment_rest;
  logic [N_PORTS-1:0] vmask;
  logic [N_PORTS-1:0] smask;
  logic [ADDR_W-1:0]  addr [N_PORTS];
  logic [IDX_W-1:0]   idx;
  logic               e_valid;
  logic               e_st;
  logic [ADDR_W-1:0]  e_addr;
  logic               e_free;
  logic               e_locked;
  expect_t            exp_prev;

  dcache_miss_cam #(
    .N_PORTS  (N_PORTS),
    .N_ENTRIES(N_ENTRIES)
  ) dcache_miss_cam_inst (
    .clk       (clk),
    .rst       (rst),
    .miss_i    (miss),
    .rd_en_i   (rd_en),
    .rd_idx_i  (rd_idx),
    .unlock_i  (unlock),
    .refill_o  (refill),
    .has_free_o(has_free),
    .locked_o  (locked)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ==============================
  // Reporting and checks
  // ==============================

  task automatic abort_run(input string why);
    $display("ERROR %s (vector line %0d)", why, line_no);
    $display("TB FAILED");
    $fatal(1, "Run aborted");
  endtask

  task automatic value_mismatch(input string name, input logic [63:0] got,
                                input logic [63:0] expected);
    $display("MISMATCH %s got 0x%0h expected 0x%0h (vector line %0d)",
             name, got, expected, prev_line);
    $display("TB FAILED");
    $fatal(1, "Output check failed");
  endtask

  task automatic check_previous();
    if (have_prev) begin
      assert (refill.valid == exp_prev.valid)
        else value_mismatch("refill_o.valid", 64'(refill.valid), 64'(exp_prev.valid));
      if (exp_prev.valid) begin // Payload is only meaningful on a valid refill
        assert (refill.st == exp_prev.st)
          else value_mismatch("refill_o.st", 64'(refill.st), 64'(exp_prev.st));
        assert (refill.line_addr == exp_prev.line_addr)
          else value_mismatch("refill_o.line_addr", 64'(refill.line_addr),
                              64'(exp_prev.line_addr));
      end
      assert (has_free == exp_prev.has_free)
        else value_mismatch("has_free_o", 64'(has_free), 64'(exp_prev.has_free));
      assert (locked == exp_prev.locked)
        else value_mismatch("locked_o", 64'(locked), 64'(exp_prev.locked));
    end
  endtask

  task automatic drive_vector();
    logic is_miss;
    is_miss = (cmd == CMD_MISS);
    if (!is_miss && cmd != CMD_READ && cmd != CMD_UNLOCK && cmd != CMD_IDLE) begin
      abort_run("Unknown command in vector file");
    end
    for (int p = 0; p < N_PORTS; p++) begin
      miss[p].valid     <= is_miss && vmask[p];
      miss[p].st        <= smask[p];
      miss[p].line_addr <= addr[p];
    end
    rd_en  <= (cmd == CMD_READ);
    rd_idx <= idx;
    unlock <= (cmd == CMD_UNLOCK);
  endtask

  // ==============================
  // Vector run
  // ==============================

  initial begin
    rst       = 1'b1;
    miss      = '0;
    rd_en     = 1'b0;
    rd_idx    = '0;
    unlock    = 1'b0;
    cycles    = 0;
    line_no   = 0;
    prev_line = 0;
    have_prev = 1'b0;
    done      = 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    fd = $fopen("verification/miss_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open verification/miss_vectors.txt");
    end

    // One line per clock, its outputs are checked on the following clock
    while (!done) begin
      line_no++;
      code = $fscanf(fd, "%s", cmd);
      if (code != 1) begin
        done = 1'b1;
      end else if (cmd == CMD_COMMENT) begin
        code = $fgets(comment_rest, fd);
      end else begin
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h\n", vmask, smask,
                       addr[0], addr[1], addr[2], addr[3], idx,
                       e_valid, e_st, e_addr, e_free, e_locked);
        if (code != 12) begin
          abort_run("Malformed vector line");
        end
        @(posedge clk);
        drive_vector();
        @(negedge clk);
        check_previous();
        exp_prev.valid     = e_valid;
        exp_prev.st        = e_st;
        exp_prev.line_addr = e_addr;
        exp_prev.has_free  = e_free;
        exp_prev.locked    = e_locked;
        prev_line          = line_no;
        have_prev          = 1'b1;
        cycles++;
        if (cycles > MAX_CYCLES) begin
          abort_run("Vector run exceeded its cycle limit");
        end
      end
    end
    $fclose(fd);

    cmd = CMD_IDLE; // Flush the last line's checks
    @(posedge clk);
    drive_vector();
    @(negedge clk);
    check_previous();

    if (dcache_miss_cam_inst.miss_cam_properties_inst.fail_count == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("TB FAILED");
      $fatal(1, "Bound assertions failed");
    end
  end

endmodule
